// File: verif/fetch_input.txt
# I addr b0..b15 : image line, all hex
# E eip length opcode modrm disp_size imm_size illegal : expected decode, in order
# R count eip : redirect once count instructions are delivered ; L cs_limit eip : limit fault
I 000 90 89 D8 8B 45 08 8B 04 24 8B 04 25 00 10 00 00
I 010 66 B8 34 12 05 78 56 34 12 3E 8B 85 00 01 00 00
I 020 F3 66 2E C7 40 04 11 11 83 C0 01 0F 84 10 00 00
I 030 00 81 84 24 00 01 00 00 78 56 34 12 6A 7F 68 01
I 040 02 03 04 D6 E8 00 00 00 00 EB 05 01 C8 03 0C 8D
I 050 00 20 00 00 C3 90 90 90 90 90 90 90 90 90 90 90
I 100 CC CC CC CC CC CC CC 64 8B 03 90 C3 90 90 90 90
I 200 B9 00 00 00 00 2E C7 05 00 30 00 00 EF BE AD DE
I 210 90 8B 44 24 10 68 11 22 33 44 90 90 90 90 90 90
E 000 1 0090 00 0 0 0
E 001 2 0089 D8 0 0 0
E 003 3 008B 45 1 0 0
E 006 3 008B 04 0 0 0
E 009 7 008B 04 4 0 0
E 010 4 00B8 00 0 2 0
E 014 5 0005 00 0 4 0
E 019 7 008B 85 4 0 0
E 020 8 00C7 40 1 2 0
E 028 3 0083 C0 0 1 0
E 02B 6 0F84 00 0 4 0
E 031 B 0081 84 4 4 0
E 03C 2 006A 00 0 1 0
E 03E 5 0068 00 0 4 0
E 043 1 00D6 00 0 0 1
E 044 5 00E8 00 0 4 0
E 049 2 00EB 00 0 1 0
E 04B 2 0001 C8 0 0 0
E 04D 7 0003 0C 4 0 0
E 054 1 00C3 00 0 0 0
R 14 107
E 107 3 008B 03 0 0 0
E 10A 1 0090 00 0 0 0
E 10B 1 00C3 00 0 0 0
R 17 200
E 200 5 00B9 00 0 4 0
E 205 B 00C7 05 4 4 0
E 210 1 0090 00 0 0 0
E 211 4 008B 44 1 0 0
L 218 215

// File: filelist.f
design/fetch_pkg.sv
design/fetch_buf_if.sv
design/fetch_ctrl.sv
design/fetch_pointers.sv
design/line_buffer.sv
design/length_decoder.sv
design/fetch_top.sv
verif/fetch_props.sv
verif/fetch_tb.sv

// File: Bender.yml
package:
  name: fetch_frontend

sources:
  - design/fetch_pkg.sv
  - design/fetch_buf_if.sv
  - design/fetch_ctrl.sv
  - design/fetch_pointers.sv
  - design/line_buffer.sv
  - design/length_decoder.sv
  - design/fetch_top.sv
  - target: simulation
    files:
      - verif/fetch_props.sv
      - verif/fetch_tb.sv

// File: verif/fetch_tb.sv
// testbench for fetch_top with cache model, random consumer, redirects and decode checks
`timescale 1ns/10ps

module fetch_tb;
  logic clk;
  logic reset;
  logic load_eip;
  logic [31:0] eip;
  logic [31:0] cs_limit;
  logic icache_ready;
  logic [127:0] icache_data;
  logic instr_ready;
  logic icache_en;
  logic [31:0] icache_address;
  logic instr_valid;
  logic segment_limit_exception;
  logic [31:0] eip_out;
  logic [3:0] instr_length;
  logic [15:0] opcode;
  logic [1:0] prefix_count;
  logic operand_override;
  logic repeat_prefix;
  logic segment_override;
  logic [2:0] seg_id;
  logic modrm_present;
  logic sib_present;
  logic [7:0] modrm;
  logic [7:0] sib;
  logic [2:0] disp_size;
  logic [2:0] imm_size;
  logic illegal;

  logic [7:0] mem [1024];
  logic [31:0] exp_rec [64][7];
  logic [31:0] redir_idx [8];
  logic [31:0] redir_eip [8];
  int n_exp;
  int n_redir;
  int n_done;
  int redir_next;
  int redir_wait;
  int errors;
  int cycles;
  logic has_limit;
  logic [31:0] limit_eip;
  logic done;
  logic [15:0] lfsr;
  logic line_busy;
  logic [1:0] ready_delay;
  logic [31:0] read_eip;
  logic [31:0] fetch_next;
  logic discard_pending;

  fetch_top u_dut (.*);

  always #10 clk = ~clk;

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic next_random_bit();
    logic fb;
    fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
    lfsr = {lfsr[14:0], fb};
    return fb;
  endfunction

  function automatic logic [1:0] random_two_bits();
    logic [1:0] v;
    v[0] = next_random_bit();
    v[1] = next_random_bit();
    return v;
  endfunction

  function automatic logic [7:0] fill_byte(input logic [31:0] a);
    return a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ 8'hA5;
  endfunction

  function automatic logic [7:0] image_byte(input logic [31:0] a);
    return (a < 1024) ? mem[a] : fill_byte(a);
  endfunction

  function automatic logic [127:0] read_line(input logic [31:0] addr);
    logic [127:0] d;
    for (int i = 0; i < 16; i++)
    begin
      d[8*i +: 8] = image_byte(addr + 32'(i));
    end
    return d;
  endfunction

  // segment register number of an override prefix or 7 for any other byte
  function automatic logic [2:0] seg_number(input logic [7:0] b);
    case (b)
      8'h26: return 3'd0;
      8'h2E: return 3'd1;
      8'h36: return 3'd2;
      8'h3E: return 3'd3;
      8'h64: return 3'd4;
      8'h65: return 3'd5;
      default: return 3'd7;
    endcase
  endfunction

  task automatic check_value(input string test, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual)
    begin
      errors++;
      $display("** Error [%s] expected %h actual %h", test, expected, actual);
    end
  endtask

  // prefix and modrm side fields worked out from the image bytes of the record
  task automatic check_side_fields(input int rec);
    logic [31:0] a;
    logic [7:0] b;
    logic [15:0] op;
    logic [7:0] mrm;
    int n_pfx;
    int op_len;
    logic opsz_e;
    logic rep_e;
    logic [2:0] seg_e;
    logic mrm_e;
    logic sib_e;
    string tag;
    a = exp_rec[rec][0];
    op = exp_rec[rec][2][15:0];
    mrm = exp_rec[rec][3][7:0];
    tag = $sformatf("rec %0d", rec);
    n_pfx = 0;
    opsz_e = 1'b0;
    rep_e = 1'b0;
    seg_e = 3'd7;
    while (n_pfx < 3)
    begin
      b = image_byte(a + 32'(n_pfx));
      if (b == 8'h66)
        opsz_e = 1'b1;
      else if (b == 8'hF2 || b == 8'hF3)
        rep_e = 1'b1;
      else if (seg_number(b) != 3'd7)
        seg_e = seg_number(b);
      else
        break;
      n_pfx++;
    end
    case (op)
      16'h0001, 16'h0003, 16'h0089, 16'h008B, 16'h0081, 16'h00C7, 16'h0083: mrm_e = 1'b1;
      default: mrm_e = 1'b0;
    endcase
    sib_e = mrm_e && (mrm[7:6] != 2'b11) && (mrm[2:0] == 3'b100);
    op_len = (op[15:8] == 8'h0F) ? 2 : 1;
    check_value({tag, " prefix count"}, 32'(n_pfx), 32'(prefix_count));
    check_value({tag, " operand override"}, 32'(opsz_e), 32'(operand_override));
    check_value({tag, " repeat"}, 32'(rep_e), 32'(repeat_prefix));
    check_value({tag, " segment override"}, 32'(seg_e != 3'd7), 32'(segment_override));
    if (seg_e != 3'd7)
      check_value({tag, " segment id"}, 32'(seg_e), 32'(seg_id));
    check_value({tag, " modrm present"}, 32'(mrm_e), 32'(modrm_present));
    check_value({tag, " sib present"}, 32'(sib_e), 32'(sib_present));
    if (sib_e)
      check_value({tag, " sib"}, 32'(image_byte(a + 32'(n_pfx + op_len + 1))),
                  32'(sib));
  endtask

  task automatic load_input();
    int fd;
    int cnt;
    string line;
    logic [31:0] addr;
    logic [7:0] b [16];
    fd = $fopen("verif/fetch_input.txt", "r");
    if (fd == 0)
    begin
      $display("could not open the stimulus file verif/fetch_input.txt");
      errors++;
      return;
    end
    while (!$feof(fd))
    begin
      line = "";
      cnt = $fgets(line, fd);
      if (line.len() < 2 || line[0] == "#")
        continue;
      case (line[0])
        "I":
        begin
          cnt = $sscanf(line, "I %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h", addr,
                        b[0], b[1], b[2], b[3], b[4], b[5], b[6], b[7],
                        b[8], b[9], b[10], b[11], b[12], b[13], b[14], b[15]);
          for (int i = 0; i < 16; i++)
          begin
            if (addr + 32'(i) < 1024)
              mem[addr + 32'(i)] = b[i];
          end
        end
        "E":
        begin
          cnt = $sscanf(line, "E %h %h %h %h %h %h %h", exp_rec[n_exp][0], exp_rec[n_exp][1],
                        exp_rec[n_exp][2], exp_rec[n_exp][3], exp_rec[n_exp][4],
                        exp_rec[n_exp][5], exp_rec[n_exp][6]);
          n_exp++;
        end
        "R":
        begin
          cnt = $sscanf(line, "R %h %h", redir_idx[n_redir], redir_eip[n_redir]);
          n_redir++;
        end
        "L":
        begin
          cnt = $sscanf(line, "L %h %h", cs_limit, limit_eip);
          has_limit = 1'b1;
        end
        default: ;
      endcase
    end
    $fclose(fd);
  endtask

  // inputs change on the falling edge only
  always @(negedge clk)
  begin
    if (reset)
    begin
      icache_ready = 1'b0;
      instr_ready = 1'b0;
      load_eip = 1'b0;
      line_busy = 1'b0;
    end
    else
    begin
      load_eip = 1'b0;
      if (icache_ready)
      begin
        icache_ready = 1'b0;
        line_busy = 1'b0;
      end
      else if (icache_en)
      begin
        if (!line_busy)
        begin
          line_busy = 1'b1;
          ready_delay = random_two_bits();
        end
        if (ready_delay == 0)
        begin
          icache_data = read_line(icache_address);
          icache_ready = 1'b1;
        end
        else
          ready_delay--;
      end
      // hold the consumer while a redirect is due and aim it at a line in flight
      if (redir_next < n_redir && n_done == redir_idx[redir_next])
      begin
        instr_ready = 1'b0;
        if ((icache_en && !icache_ready) || redir_wait >= 8)
        begin
          load_eip = 1'b1;
          eip = redir_eip[redir_next];
          redir_next++;
          redir_wait = 0;
        end
        else
          redir_wait++;
      end
      else
        instr_ready = (random_two_bits() != 2'b00);
    end
  end

  always @(posedge clk)
  begin
    cycles++;
    if (!reset && !done)
    begin
      if (icache_en && icache_ready)
      begin
        if (load_eip || discard_pending)
          discard_pending = 1'b0;
        else
        begin
          check_value("line address", fetch_next, icache_address);
          if (fetch_next + 32'd16 - {read_eip[31:4], 4'h0} > 32'd64)
          begin
            errors++;
            $display("line at %h accepted while the buffer was already full", fetch_next);
          end
          fetch_next = fetch_next + 32'd16;
        end
      end
      if (load_eip)
      begin
        discard_pending = icache_en && !icache_ready;
        fetch_next = {eip[31:4], 4'h0};
        read_eip = eip;
      end
      else if (instr_valid && instr_ready)
      begin
        if (n_done >= n_exp)
        begin
          errors++;
          $display("an instruction at %h was delivered after the last expected one", eip_out);
        end
        else
        begin
          check_value($sformatf("rec %0d eip chain", n_done), read_eip, eip_out);
          check_value($sformatf("rec %0d eip", n_done), exp_rec[n_done][0], eip_out);
          check_value($sformatf("rec %0d length", n_done), exp_rec[n_done][1],
                      32'(instr_length));
          check_value($sformatf("rec %0d opcode", n_done), exp_rec[n_done][2], 32'(opcode));
          check_value($sformatf("rec %0d modrm", n_done), exp_rec[n_done][3], 32'(modrm));
          check_value($sformatf("rec %0d disp", n_done), exp_rec[n_done][4], 32'(disp_size));
          check_value($sformatf("rec %0d imm", n_done), exp_rec[n_done][5], 32'(imm_size));
          check_value($sformatf("rec %0d illegal", n_done), exp_rec[n_done][6], 32'(illegal));
          check_side_fields(n_done);
          read_eip = exp_rec[n_done][0] + exp_rec[n_done][1];
          n_done++;
        end
      end
      if (segment_limit_exception)
      begin
        if (n_done < n_exp || !has_limit)
        begin
          errors++;
          $display("segment limit exception raised early at eip %h", eip_out);
          done = 1'b1;
        end
        else
        begin
          check_value("limit valid", 32'd0, 32'(instr_valid));
          check_value("limit eip", limit_eip, eip_out);
          done = 1'b1;
        end
      end
      if (n_done == n_exp && !has_limit && n_exp > 0)
        done = 1'b1;
    end
  end

  initial
  begin
    int limit;
    clk = 1'b0;
    reset = 1'b1;
    load_eip = 1'b0;
    eip = '0;
    cs_limit = 32'hFFFF_FFFF;
    icache_ready = 1'b0;
    icache_data = '0;
    instr_ready = 1'b0;
    lfsr = 16'd9198;
    errors = 0;
    cycles = 0;
    n_exp = 0;
    n_redir = 0;
    n_done = 0;
    redir_next = 0;
    redir_wait = 0;
    has_limit = 1'b0;
    limit_eip = '0;
    done = 1'b0;
    read_eip = '0;
    fetch_next = '0;
    discard_pending = 1'b0;
    for (int a = 0; a < 1024; a++)
      mem[a] = fill_byte(32'(a));
    load_input();
    limit = 40 * (n_exp + 1);
    repeat (8) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    while (!done && cycles < limit)
      @(posedge clk);
    if (!done)
    begin
      errors++;
      $display("timeout after %0d cycles with %0d of %0d instructions seen",
               cycles, n_done, n_exp);
    end
    $display("errors: %0d, instructions checked: %0d of %0d", errors, n_done, n_exp);
    if (errors == 0)
      $display("Simulation PASSED");
    else
      $display("Simulation FAILED");
    $finish;
  end

endmodule

// File: verif/fetch_props.sv
// handshake stability and reset state assertions for fetch_top
`timescale 1ns/10ps

module fetch_props (
  input logic clk,
  input logic reset,
  input logic load_eip,
  input logic instr_ready,
  input logic icache_en,
  input logic icache_ready,
  input logic [31:0] icache_address,
  input logic instr_valid,
  input logic [31:0] eip_out,
  input logic [3:0] instr_length,
  input logic [15:0] opcode,
  input logic [7:0] modrm,
  input logic [7:0] sib,
  input logic [2:0] disp_size,
  input logic [2:0] imm_size,
  input logic illegal
);

  // request address held until the cache answers
  assert property (@(posedge clk) disable iff (reset)
    icache_en && !icache_ready |=> $stable(icache_address))
  else $error("icache_address changed while a request was pending");

  assert property (@(posedge clk) disable iff (reset)
    instr_valid && !instr_ready && !load_eip |=> instr_valid && $stable({eip_out,
      instr_length, opcode, modrm, sib, disp_size, imm_size, illegal}))
  else $error("instruction outputs changed during a consumer stall");

  assert property (@(posedge clk) $past(reset) |-> !icache_en && !instr_valid)
  else $error("icache_en or instr_valid high right after reset");

endmodule

bind fetch_top fetch_props u_props (.*);

// File: design/fetch_top.sv
// instruction fetch front end top level
`timescale 1ns/10ps

module fetch_top #(
  parameter int line_bytes = fetch_pkg::line_bytes,
  parameter int num_slots = fetch_pkg::num_slots
) (
  input logic clk,
  input logic reset,
  input logic load_eip,
  input logic [31:0] eip,
  input logic [31:0] cs_limit,
  input logic icache_ready,
  input logic [127:0] icache_data,
  input logic instr_ready,
  output logic icache_en,
  output logic [31:0] icache_address,
  output logic instr_valid,
  output logic segment_limit_exception,
  output logic [31:0] eip_out,
  output logic [3:0] instr_length,
  output logic [15:0] opcode,
  output logic [1:0] prefix_count,
  output logic operand_override,
  output logic repeat_prefix,
  output logic segment_override,
  output logic [2:0] seg_id,
  output logic modrm_present,
  output logic sib_present,
  output logic [7:0] modrm,
  output logic [7:0] sib,
  output logic [2:0] disp_size,
  output logic [2:0] imm_size,
  output logic illegal
);
  import fetch_pkg::*;

  decoded_instr_t instr;
  logic [8*line_bytes-1:0] window;
  logic [31:0] cur_eip;

  fetch_buf_if #(.line_bytes(line_bytes), .num_slots(num_slots)) buf_if (.clk(clk));

  fetch_ctrl u_ctrl (
    .clk(clk),
    .reset(reset),
    .load_eip(load_eip),
    .eip(eip),
    .icache_ready(icache_ready),
    .icache_data(icache_data),
    .instr_ready(instr_ready),
    .cs_limit(cs_limit),
    .instr(instr),
    .cur_eip(cur_eip),
    .bus(buf_if),
    .icache_en(icache_en),
    .icache_address(icache_address),
    .instr_valid(instr_valid),
    .segment_limit_exception(segment_limit_exception)
  );

  fetch_pointers #(.line_bytes(line_bytes), .num_slots(num_slots)) u_ptrs (
    .clk(clk),
    .reset(reset),
    .eip(eip),
    .length(instr.length),
    .bus(buf_if),
    .cur_eip(cur_eip)
  );

  line_buffer #(.line_bytes(line_bytes), .num_slots(num_slots)) u_buf (
    .clk(clk),
    .reset(reset),
    .bus(buf_if),
    .window(window)
  );

  length_decoder u_dec (
    .window(window),
    .instr(instr)
  );

  assign eip_out = cur_eip;
  assign instr_length = instr.length;
  assign opcode = instr.opcode;
  assign prefix_count = instr.prefix_count;
  assign operand_override = instr.operand_override;
  assign repeat_prefix = instr.repeat_prefix;
  assign segment_override = instr.segment_override;
  assign seg_id = instr.seg_id;
  assign modrm_present = instr.modrm_present;
  assign sib_present = instr.sib_present;
  assign modrm = instr.modrm;
  assign sib = instr.sib;
  assign disp_size = instr.disp_size;
  assign imm_size = instr.imm_size;
  assign illegal = instr.illegal;

endmodule

// File: design/length_decoder.sv
// prefix, opcode, modrm/sib, displacement and immediate length decoder
`timescale 1ns/10ps

module length_decoder (
  input logic [127:0] window,
  output fetch_pkg::decoded_instr_t instr
);
  import fetch_pkg::*;

  logic [1:0] pfx_n;
  logic scan;
  logic [7:0] cur;
  logic opsz, rep, segov;
  logic [2:0] seg;
  logic [7:0] op0, op1;
  logic two_byte, legal, has_modrm, imm8, immz;
  logic [3:0] op_end;
  logic [7:0] mrm, sib_b;
  logic sib_on;
  logic [2:0] disp_n, imm_n;

  function automatic logic [7:0] byte_at(input logic [127:0] w, input logic [3:0] idx);
    return w[{idx, 3'b000} +: 8];
  endfunction

  always_comb
  begin
    pfx_n = 2'd0;
    scan = 1'b1;
    opsz = 1'b0;
    rep = 1'b0;
    segov = 1'b0;
    seg = 3'd3;
    // at most three prefixes, a fourth falls through as the opcode
    for (int i = 0; i < 3; i++)
    begin
      cur = byte_at(window, 4'(i));
      if (scan)
      begin
        case (cur)
          pfx_opsize: opsz = 1'b1;
          pfx_repne, pfx_rep: rep = 1'b1;
          pfx_es, pfx_cs, pfx_ss, pfx_ds:
          begin
            segov = 1'b1;
            seg = {1'b0, cur[4:3]};
          end
          pfx_fs, pfx_gs:
          begin
            segov = 1'b1;
            seg = {2'b10, cur[0]};
          end
          default: scan = 1'b0;
        endcase
        if (scan)
          pfx_n = pfx_n + 2'd1;
      end
    end

    op0 = byte_at(window, {2'b00, pfx_n});
    op1 = byte_at(window, {2'b00, pfx_n} + 4'd1);
    two_byte = (op0 == op_escape);
    legal = 1'b1;
    has_modrm = 1'b0;
    imm8 = 1'b0;
    immz = 1'b0;
    if (two_byte)
    begin
      immz = (op1 == op_jcc_rel);
      legal = immz;
    end
    else
    begin
      case (op0)
        op_add_rm_r, op_add_r_rm, op_mov_rm_r, op_mov_r_rm: has_modrm = 1'b1;
        op_add_eax_imm, op_push_imm, op_call_rel: immz = 1'b1;
        op_push_imm8, op_jmp_rel8: imm8 = 1'b1;
        op_grp1_imm, op_mov_rm_imm:
        begin
          has_modrm = 1'b1;
          immz = 1'b1;
        end
        op_grp1_imm8:
        begin
          has_modrm = 1'b1;
          imm8 = 1'b1;
        end
        op_nop, op_ret: legal = 1'b1;
        default:
        begin
          // B8..BF, register in the low three bits
          immz = (op0[7:3] == op_mov_r_imm[7:3]);
          legal = immz;
        end
      endcase
    end

    op_end = {2'b00, pfx_n} + (two_byte ? 4'd2 : 4'd1);
    mrm = byte_at(window, op_end);
    sib_b = byte_at(window, op_end + 4'd1);
    sib_on = has_modrm && (mrm[7:6] != 2'b11) && (mrm[2:0] == 3'b100);
    disp_n = 3'd0;
    if (has_modrm)
    begin
      case (mrm[7:6])
        2'b01: disp_n = 3'd1;
        2'b10: disp_n = 3'd4;
        2'b00:
          if (mrm[2:0] == 3'b101 || (sib_on && sib_b[2:0] == 3'b101))
            disp_n = 3'd4;
        default: disp_n = 3'd0;
      endcase
    end
    imm_n = imm8 ? 3'd1 : (immz ? (opsz ? 3'd2 : 3'd4) : 3'd0);

    instr = '0;
    instr.opcode = two_byte ? {op_escape, op1} : {8'h00, op0};
    instr.prefix_count = pfx_n;
    instr.operand_override = opsz;
    instr.repeat_prefix = rep;
    instr.segment_override = segov;
    instr.seg_id = seg;
    if (legal)
    begin
      instr.length = op_end + 4'(has_modrm) + 4'(sib_on) + 4'(disp_n) + 4'(imm_n);
      instr.modrm_present = has_modrm;
      instr.sib_present = sib_on;
      instr.modrm = has_modrm ? mrm : 8'h00;
      instr.sib = sib_on ? sib_b : 8'h00;
      instr.disp_size = disp_n;
      instr.imm_size = imm_n;
    end
    else
    begin
      // unknown opcode consumes a single byte
      instr.length = 4'd1;
      instr.illegal = 1'b1;
    end
  end

endmodule

// File: design/line_buffer.sv
// line slot registers and two level byte shifter for the decode window
`timescale 1ns/10ps

module line_buffer #(
  parameter int line_bytes = fetch_pkg::line_bytes,
  parameter int num_slots = fetch_pkg::num_slots
) (
  input logic clk,
  input logic reset,
  fetch_buf_if.buffer bus,
  output logic [8*line_bytes-1:0] window
);
  localparam int line_w = 8 * line_bytes;
  localparam int off_w = $clog2(line_bytes);
  localparam int ptr_w = $clog2(line_bytes * num_slots);

  logic [line_w-1:0] slot_q [num_slots];
  logic [2*line_w-1:0] pair_shift [num_slots];
  logic [off_w+2:0] shift_bits;

  assign shift_bits = {bus.read_ptr[off_w-1:0], 3'b000};

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      for (int s = 0; s < num_slots; s++)
      begin
        slot_q[s] <= '0;
      end
    end
    else if (bus.slot_we)
    begin
      slot_q[bus.write_slot] <= bus.line_data;
    end
  end

  // each slot joined with its successor, the last one wraps to slot 0
  for (genvar s = 0; s < num_slots; s++)
  begin : g_pair
    assign pair_shift[s] = {slot_q[(s + 1) % num_slots], slot_q[s]} >> shift_bits;
  end

  // pick the pair starting at the read slot
  assign window = pair_shift[bus.read_ptr[ptr_w-1:off_w]][line_w-1:0];

endmodule

// File: design/fetch_pointers.sv
// read pointer, write slot, fill level and instruction pointer counters
`timescale 1ns/10ps

module fetch_pointers #(
  parameter int line_bytes = fetch_pkg::line_bytes,
  parameter int num_slots = fetch_pkg::num_slots
) (
  input logic clk,
  input logic reset,
  input logic [31:0] eip,
  input logic [3:0] length,
  fetch_buf_if.ptrs bus,
  output logic [31:0] cur_eip
);
  localparam int ptr_w = $clog2(line_bytes * num_slots);
  localparam int slot_w = $clog2(num_slots);
  localparam int off_w = $clog2(line_bytes);

  logic [ptr_w-1:0] rd_ptr;
  logic [slot_w-1:0] wr_slot;
  // two's complement, negative right after a redirect to an unaligned eip
  logic [ptr_w+1:0] count;
  logic [ptr_w+1:0] step_in;
  logic [ptr_w+1:0] step_out;

  assign step_in = bus.slot_we ? (ptr_w + 2)'(line_bytes) : '0;
  assign step_out = bus.advance ? (ptr_w + 2)'(length) : '0;

  assign bus.read_ptr = rd_ptr;
  assign bus.write_slot = wr_slot;
  assign bus.bytes_avail = count[ptr_w+1] ? '0 : count[ptr_w:0];

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      rd_ptr <= '0;
      wr_slot <= '0;
      count <= '0;
      cur_eip <= '0;
    end
    else if (bus.flush)
    begin
      rd_ptr <= {{(ptr_w - off_w){1'b0}}, eip[off_w-1:0]};
      wr_slot <= '0;
      count <= '0 - {{(ptr_w + 2 - off_w){1'b0}}, eip[off_w-1:0]};
      cur_eip <= eip;
    end
    else
    begin
      rd_ptr <= rd_ptr + step_out[ptr_w-1:0];
      count <= count + step_in - step_out;
      cur_eip <= cur_eip + 32'(step_out);
      if (bus.slot_we)
        wr_slot <= wr_slot + 1'b1;
    end
  end

endmodule

// File: design/fetch_ctrl.sv
// line request FSM, redirect handling and instruction delivery gating
`timescale 1ns/10ps

module fetch_ctrl (
  input logic clk,
  input logic reset,
  input logic load_eip,
  input logic [31:0] eip,
  input logic icache_ready,
  input logic [127:0] icache_data,
  input logic instr_ready,
  input logic [31:0] cs_limit,
  input fetch_pkg::decoded_instr_t instr,
  input logic [31:0] cur_eip,
  fetch_buf_if.ctrl bus,
  output logic icache_en,
  output logic [31:0] icache_address,
  output logic instr_valid,
  output logic segment_limit_exception
);
  import fetch_pkg::*;

  localparam int off_w = $clog2(line_bytes);

  fetch_state_t state;
  logic [31:0] fetch_addr;
  logic redirect_q;
  logic [7:0] span;
  logic [3:0] slots_used;
  logic window_full;
  logic [32:0] instr_end;
  logic limit_fail;

  // bytes from the start of the read slot to the end of written data
  assign span = bus.bytes_avail + bus.read_ptr[off_w-1:0];
  assign slots_used = 4'(span >> off_w);

  assign bus.slot_we = icache_en & icache_ready & (state == request) & ~load_eip;
  assign bus.line_data = icache_data;
  assign bus.flush = load_eip;
  assign bus.advance = instr_valid & instr_ready;

  // last byte of the instruction against the code segment limit
  assign instr_end = {1'b0, cur_eip} + 33'(instr.length) - 33'd1;
  assign limit_fail = instr_end > {1'b0, cs_limit};
  assign window_full = bus.bytes_avail >= line_bytes;

  assign instr_valid = window_full & ~redirect_q & ~limit_fail;
  assign segment_limit_exception = window_full & ~redirect_q & limit_fail;

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state <= request;
      icache_en <= 1'b0;
      icache_address <= '0;
      fetch_addr <= '0;
      redirect_q <= 1'b0;
    end
    else
    begin
      redirect_q <= load_eip;
      if (load_eip)
      begin
        fetch_addr <= {eip[31:off_w], {off_w{1'b0}}};
        // a line still in flight must be absorbed before the new stream starts
        if (icache_en && !icache_ready)
          state <= discard;
        else
        begin
          state <= request;
          icache_en <= 1'b0;
        end
      end
      else
      begin
        case (state)
          idle:
            if (slots_used < num_slots)
              state <= request;
          request:
            if (!icache_en)
            begin
              icache_en <= 1'b1;
              icache_address <= fetch_addr;
            end
            else if (icache_ready)
            begin
              icache_en <= 1'b0;
              fetch_addr <= fetch_addr + 32'(line_bytes);
              state <= (slots_used + 1 < num_slots) ? request : idle;
            end
          discard:
            if (icache_ready)
            begin
              icache_en <= 1'b0;
              state <= request;
            end
          default: state <= idle;
        endcase
      end
    end
  end

endmodule

// File: design/fetch_buf_if.sv
// slot write, read pointer and fill level signals shared by the fetch blocks
`timescale 1ns/10ps

interface fetch_buf_if #(
  parameter int line_bytes = fetch_pkg::line_bytes,
  parameter int num_slots = fetch_pkg::num_slots
) (
  input logic clk
);
  localparam int ptr_w = $clog2(line_bytes * num_slots);
  localparam int slot_w = $clog2(num_slots);

  logic slot_we;
  logic [8*line_bytes-1:0] line_data;
  logic [slot_w-1:0] write_slot;
  logic [ptr_w-1:0] read_ptr;
  // 0 up to the whole buffer, hence one extra bit
  logic [ptr_w:0] bytes_avail;
  logic advance;
  logic flush;

  modport ctrl (output slot_we, line_data, advance, flush, input read_ptr, bytes_avail);
  modport ptrs (input slot_we, advance, flush, output write_slot, read_ptr, bytes_avail);
  modport buffer (input slot_we, line_data, write_slot, read_ptr);

endinterface

// File: design/fetch_pkg.sv
// buffer sizes, fetch states, prefix and opcode constants, decoded instruction record
package fetch_pkg;

  localparam int line_bytes = 16;
  localparam int num_slots = 4;

  typedef enum logic [1:0] {idle, request, discard} fetch_state_t;

  // legacy prefixes
  localparam logic [7:0] pfx_opsize = 8'h66;
  localparam logic [7:0] pfx_repne = 8'hF2;
  localparam logic [7:0] pfx_rep = 8'hF3;
  localparam logic [7:0] pfx_es = 8'h26;
  localparam logic [7:0] pfx_cs = 8'h2E;
  localparam logic [7:0] pfx_ss = 8'h36;
  localparam logic [7:0] pfx_ds = 8'h3E;
  localparam logic [7:0] pfx_fs = 8'h64;
  localparam logic [7:0] pfx_gs = 8'h65;

  // opcode subset
  localparam logic [7:0] op_add_rm_r = 8'h01;
  localparam logic [7:0] op_add_r_rm = 8'h03;
  localparam logic [7:0] op_mov_rm_r = 8'h89;
  localparam logic [7:0] op_mov_r_rm = 8'h8B;
  localparam logic [7:0] op_add_eax_imm = 8'h05;
  localparam logic [7:0] op_push_imm = 8'h68;
  localparam logic [7:0] op_mov_r_imm = 8'hB8;
  localparam logic [7:0] op_call_rel = 8'hE8;
  localparam logic [7:0] op_push_imm8 = 8'h6A;
  localparam logic [7:0] op_jmp_rel8 = 8'hEB;
  localparam logic [7:0] op_grp1_imm = 8'h81;
  localparam logic [7:0] op_mov_rm_imm = 8'hC7;
  localparam logic [7:0] op_grp1_imm8 = 8'h83;
  localparam logic [7:0] op_nop = 8'h90;
  localparam logic [7:0] op_ret = 8'hC3;
  localparam logic [7:0] op_escape = 8'h0F;
  localparam logic [7:0] op_jcc_rel = 8'h84;

  typedef struct packed {
    logic [3:0] length;
    logic [15:0] opcode;
    logic [1:0] prefix_count;
    logic operand_override;
    logic repeat_prefix;
    logic segment_override;
    logic [2:0] seg_id;
    logic modrm_present;
    logic sib_present;
    logic [7:0] modrm;
    logic [7:0] sib;
    logic [2:0] disp_size;
    logic [2:0] imm_size;
    logic illegal;
  } decoded_instr_t;

endpackage
